/* design/arbFixed.sv */
// Fixed-priority arbiter, lowest requesting index wins in the same cycle

`timescale 1ns/1ps
`default_nettype none

module arbFixed (
  input  flowMuxPkg::flowMask_t request,
  output flowMuxPkg::flowMask_t canGrant,
  output flowMuxPkg::flowMask_t grant
);

  // ----------------------------------------
  // Priority scan
  // ----------------------------------------

  // Running OR of all requests below the current index
  // Bit i is set when some index lower than i is requesting
  flowMuxPkg::flowMask_t lowerReq;

  always_comb begin
    lowerReq = '0;
    // Index 0 has nothing below it, so it is never blocked
    for (int i = 1; i < flowMuxPkg::NumFlows; i++) begin
      lowerReq[i] = lowerReq[i-1] | request[i-1];
    end
  end

  // An index may win only if no lower index is asking
  // This is independent of the index's own request bit
  assign canGrant = ~lowerReq;

  // ----------------------------------------
  // Grant
  // ----------------------------------------

  // Mask requests with the permission vector
  // At most one bit survives, the lowest set request
  // Higher indices starve while a lower one keeps requesting,
  // which is the intended fixed-priority behavior
  assign grant = request & canGrant;

endmodule : arbFixed

`default_nettype wire

/* design/flowMuxCore.sv */
// Mux core, steers the granted push word toward the output stage and returns push ready

`timescale 1ns/1ps
`default_nettype none

module flowMuxCore (
  // Push lanes
  input  flowMuxPkg::flowMask_t    pushValid,
  input  flowMuxPkg::flowDataArr_t pushData,
  output flowMuxPkg::flowMask_t    pushReady,

  // Arbiter link
  input  flowMuxPkg::flowMask_t    grant,
  output flowMuxPkg::flowMask_t    request,

  // Toward the output register
  output logic                     midValid,
  output flowMuxPkg::flowData_t    midData,
  input  logic                     midReady
);

  // ----------------------------------------
  // Request side
  // ----------------------------------------

  // Every valid lane competes, no extra qualification
  assign request = pushValid;

  // Some lane has a word, so the arbiter is sure to pick one
  assign midValid = |pushValid;

  // ----------------------------------------
  // Data steering
  // ----------------------------------------

  // Each lane's word, zeroed unless that lane holds the grant
  flowMuxPkg::flowDataArr_t laneGated;

  for (genvar g = 0; g < flowMuxPkg::NumFlows; g++) begin : gLane
    // Replicate the grant bit across the word
    assign laneGated[g] = pushData[g] & {flowMuxPkg::Width{grant[g]}};
  end

  // OR the gated words together
  // Grant is onehot or zero, so this yields the winner's word or zero
  always_comb begin
    midData = '0;
    for (int i = 0; i < flowMuxPkg::NumFlows; i++) begin
      midData = midData | laneGated[i];
    end
  end

  // ----------------------------------------
  // Ready return
  // ----------------------------------------

  // Only the winner sees ready, and only when the output stage can take it
  // Losing lanes hold their word until they win
  assign pushReady = grant & {flowMuxPkg::NumFlows{midReady}};

endmodule : flowMuxCore

`default_nettype wire

/* design/flowMuxFixedStable.sv */
// Fixed-priority flow multiplexer with a registered, stable pop side

`timescale 1ns/1ps
`default_nettype none

module flowMuxFixedStable (
  input  logic                     clk,
  input  logic                     rst,

  // Push lanes, lowest index has highest priority
  input  flowMuxPkg::flowMask_t    pushValid,
  output flowMuxPkg::flowMask_t    pushReady,
  input  flowMuxPkg::flowDataArr_t pushData,

  // Pop side, one cycle after the push is accepted
  output logic                     popValid,
  input  logic                     popReady,
  output flowMuxPkg::flowData_t    popData
);

  // ----------------------------------------
  // Internal links
  // ----------------------------------------

  // Arbiter link
  flowMuxPkg::flowMask_t request;
  flowMuxPkg::flowMask_t grant;

  // Core to output register
  logic                  midValid;
  logic                  midReady;
  flowMuxPkg::flowData_t midData;

  // ----------------------------------------
  // Arbitration
  // ----------------------------------------

  // The core only needs the final grant
  arbFixed arbFixed_i (
    .request  (request),
    .canGrant (),
    .grant    (grant)
  );

  // ----------------------------------------
  // Steering
  // ----------------------------------------

  flowMuxCore flowMuxCore_i (
    .pushValid (pushValid),
    .pushData  (pushData),
    .pushReady (pushReady),
    .grant     (grant),
    .request   (request),
    .midValid  (midValid),
    .midData   (midData),
    .midReady  (midReady)
  );

  // ----------------------------------------
  // Output stage
  // ----------------------------------------

  flowRegFwd flowRegFwd_i (
    .clk      (clk),
    .rst      (rst),
    .inValid  (midValid),
    .inData   (midData),
    .inReady  (midReady),
    .outValid (popValid),
    .outData  (popData),
    .outReady (popReady)
  );

endmodule : flowMuxFixedStable

`default_nettype wire

/* design/flowMuxPkg.sv */
// Shared sizes and vector types for the fixed-priority flow multiplexer

`default_nettype none

package flowMuxPkg;

  // ----------------------------------------
  // Sizing
  // ----------------------------------------

  // Number of push lanes feeding the mux
  localparam int NumFlows = 4;

  // Bits per data word, same on every lane and on the pop side
  localparam int Width = 16;

  // ----------------------------------------
  // Vector types
  // ----------------------------------------

  // One bit per flow
  // Carries request, canGrant, grant, pushValid and pushReady
  typedef logic [NumFlows-1:0] flowMask_t;

  // A single data word
  typedef logic [Width-1:0] flowData_t;

  // All push words side by side, lane i in element i
  // Packed so it can travel as one port
  typedef flowData_t [NumFlows-1:0] flowDataArr_t;

endpackage : flowMuxPkg

`default_nettype wire

/* design/flowRegFwd.sv */
// Forward flow register, one-entry pipeline stage that holds its word stable until popped

`timescale 1ns/1ps
`default_nettype none

module flowRegFwd (
  input  logic                  clk,
  input  logic                  rst,

  // Upstream side
  input  logic                  inValid,
  input  flowMuxPkg::flowData_t inData,
  output logic                  inReady,

  // Downstream side
  output logic                  outValid,
  output flowMuxPkg::flowData_t outData,
  input  logic                  outReady
);

  // ----------------------------------------
  // Handshake
  // ----------------------------------------

  // Upstream transfer happens this edge
  logic load;

  // Room when empty, or when the held word leaves this same edge
  // This gives one word per cycle under steady flow
  assign inReady = ~outValid | outReady;

  assign load = inValid & inReady;

  // ----------------------------------------
  // Valid flag
  // ----------------------------------------

  // When there is room the flag simply follows the incoming valid
  // A pop with nothing behind it empties the stage
  // Otherwise the flag holds, keeping outValid high through a stall
  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
    end else if (inReady) begin
      outValid <= inValid;
    end
  end

  // ----------------------------------------
  // Data register
  // ----------------------------------------

  // Written only on an upstream transfer
  // outData cannot move while outValid waits for outReady
  always_ff @(posedge clk) begin
    if (load) begin
      outData <= inData;
    end
  end

endmodule : flowRegFwd

`default_nettype wire

/* tb.f */
design/flowMuxPkg.sv
design/arbFixed.sv
design/flowMuxCore.sv
design/flowRegFwd.sv
design/flowMuxFixedStable.sv
verif/flowMuxAsserts.sv
verif/flowMuxTb.sv

/* verif/flowMuxAsserts.sv */
// Protocol assertions for the flow multiplexer bound into the top level

`timescale 1ns/1ps
`default_nettype none

module flowMuxAsserts (
  input logic                  clk,
  input logic                  rst,
  input flowMuxPkg::flowMask_t pushValid,
  input flowMuxPkg::flowMask_t pushReady,
  input logic                  popValid,
  input logic                  popReady,
  input flowMuxPkg::flowData_t popData
);

  // Running count of failed assertions
  int failCount;

  initial failCount = 0;

  // ----------------------------------------
  // Push side
  // ----------------------------------------

  // At most one lane is accepted per cycle
  assert property (@(posedge clk) disable iff (rst) $onehot0(pushReady))
    else begin
      $error("pushReady has more than one bit set: %b", pushReady);
      failCount++;
    end

  // Ready only goes to a lane that actually offers a word
  assert property (@(posedge clk) disable iff (rst) (pushReady & ~pushValid) == '0)
    else begin
      $error("pushReady %b set on a lane without pushValid %b", pushReady, pushValid);
      failCount++;
    end

  // ----------------------------------------
  // Pop side
  // ----------------------------------------

  // A stalled word keeps its valid and its value
  assert property (@(posedge clk) disable iff (rst)
    (popValid && !popReady) |=> popValid)
    else begin
      $error("popValid dropped during a stall");
      failCount++;
    end

  assert property (@(posedge clk) disable iff (rst)
    (popValid && !popReady) |=> $stable(popData))
    else begin
      $error("popData changed during a stall");
      failCount++;
    end

endmodule : flowMuxAsserts

// Attach to every instance of the top level
bind flowMuxFixedStable flowMuxAsserts flowMuxAsserts_i (
  .clk       (clk),
  .rst       (rst),
  .pushValid (pushValid),
  .pushReady (pushReady),
  .popValid  (popValid),
  .popReady  (popReady),
  .popData   (popData)
);

`default_nettype wire

/* verif/flowMuxTb.sv */
// Table-driven testbench with a reference model for the fixed-priority flow multiplexer

`timescale 1ns/1ps
`default_nettype none

module flowMuxTb;

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------

  localparam int Rows = 24;
  localparam int ResetCycles = 4;
  localparam int TimeoutCycles = (Rows + 20) * 2;

  // Columns {new request mask [4:1], popReady [0]}
  // A set mask bit gives that flow a new word once its previous word is accepted
  localparam logic [4:0] StimTable [Rows] = '{
    5'b0000_1,  // Idle right after reset
    5'b0001_1,  // Single word on flow 0
    5'b0110_1,  // Flow 1 beats flow 2
    5'b0000_1,  // Flow 2 gets its turn
    5'b1111_1,  // All offer, flow 0 wins
    5'b1111_1,  // Flow 0 again, higher lanes starve
    5'b0000_1,
    5'b0000_0,  // Back-pressure with a full register
    5'b0000_0,
    5'b0000_1,  // Release
    5'b0000_1,
    5'b0000_1,
    5'b1010_1,
    5'b0101_1,
    5'b1111_0,  // Stall with all lanes waiting
    5'b0000_0,
    5'b0000_1,
    5'b1000_1,
    5'b0100_1,
    5'b0010_1,
    5'b0001_1,
    5'b1111_1,
    5'b0000_1,
    5'b0000_1
  };

  // ----------------------------------------
  // DUT signals
  // ----------------------------------------

  logic                     clk;
  logic                     rst;
  flowMuxPkg::flowMask_t    pushValid;
  flowMuxPkg::flowMask_t    pushReady;
  flowMuxPkg::flowDataArr_t pushData;
  logic                     popValid;
  logic                     popReady;
  flowMuxPkg::flowData_t    popData;

  flowMuxFixedStable flowMuxFixedStable_i (
    .clk       (clk),
    .rst       (rst),
    .pushValid (pushValid),
    .pushReady (pushReady),
    .pushData  (pushData),
    .popValid  (popValid),
    .popReady  (popReady),
    .popData   (popData)
  );

  // ----------------------------------------
  // Model state
  // ----------------------------------------

  // Source models holding one word per flow
  flowMuxPkg::flowMask_t    srcValid;
  flowMuxPkg::flowDataArr_t srcData;

  // One-entry expected output slot
  logic                  slotValid;
  flowMuxPkg::flowData_t slotData;
  int                    slotFlow;

  // Words offered but not yet popped, oldest first
  int                    offFlow[$];
  flowMuxPkg::flowData_t offData[$];

  int valueErrors;
  int orderErrors;
  int assertErrors;
  int totalErrors;
  int cycleCount;
  int unsigned seedInit;

  always #5 clk = ~clk;

  // Watchdog
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("ERROR: run timed out after %0d cycles", cycleCount);
      $display("sim failed");
      $finish;
    end
  end

  // Lowest valid index, or -1 when no flow is valid
  function automatic int priorityWinner(input flowMuxPkg::flowMask_t valid);
    int win;
    win = -1;
    for (int f = flowMuxPkg::NumFlows - 1; f >= 0; f--) begin
      if (valid[f]) win = f;
    end
    return win;
  endfunction

  // Match a popped word against the oldest outstanding word of its flow
  task automatic matchPopped(input int flow, input flowMuxPkg::flowData_t word);
    bit found;
    found = 0;
    for (int k = 0; k < offFlow.size() && !found; k++) begin
      if (offFlow[k] == flow) begin
        if (offData[k] !== word) begin
          $display("FAIL t=%0t popData (flow %0d order) expected %h got %h",
                   $time, flow, offData[k], word);
          orderErrors++;
        end
        offFlow.delete(k);
        offData.delete(k);
        found = 1;
      end
    end
    if (!found) begin
      $display("ERROR: flow %0d popped a word that was never pushed", flow);
      orderErrors++;
    end
  endtask

  // Drive one row, check it at the falling edge and advance the model
  task automatic runCycle(input flowMuxPkg::flowMask_t newReq, input logic popRdy);
    flowMuxPkg::flowMask_t expGrant;
    flowMuxPkg::flowMask_t expReady;
    logic                  expMidReady;
    int                    winner;
    int unsigned           rnd;
    @(posedge clk);
    #1;
    // Idle sources pick up a new word from the table
    for (int f = 0; f < flowMuxPkg::NumFlows; f++) begin
      if (newReq[f] && !srcValid[f]) begin
        rnd = $urandom;
        srcData[f] = rnd[flowMuxPkg::Width-1:0];
        srcValid[f] = 1'b1;
        offFlow.push_back(f);
        offData.push_back(srcData[f]);
      end
    end
    pushValid = srcValid;
    pushData = srcData;
    popReady = popRdy;

    @(negedge clk);
    winner = priorityWinner(srcValid);
    expGrant = '0;
    if (winner >= 0) expGrant[winner] = 1'b1;
    // Register has room when empty or popped this cycle
    expMidReady = !slotValid || popRdy;
    expReady = expMidReady ? expGrant : '0;

    if (pushReady !== expReady) begin
      $display("FAIL t=%0t pushReady expected %b got %b", $time, expReady, pushReady);
      valueErrors++;
    end
    if (popValid !== slotValid) begin
      $display("FAIL t=%0t popValid expected %b got %b", $time, slotValid, popValid);
      valueErrors++;
    end
    if (slotValid && popData !== slotData) begin
      $display("FAIL t=%0t popData expected %h got %h", $time, slotData, popData);
      valueErrors++;
    end
    if (slotValid && popRdy) matchPopped(slotFlow, popData);

    // State after the coming edge
    if (expMidReady) begin
      slotValid = |srcValid;
      if (winner >= 0) begin
        slotData = srcData[winner];
        slotFlow = winner;
        srcValid[winner] = 1'b0;
      end
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    pushValid = '0;
    pushData = '0;
    popReady = 1'b0;
    srcValid = '0;
    srcData = '0;
    slotValid = 1'b0;
    slotData = '0;
    slotFlow = 0;
    valueErrors = 0;
    orderErrors = 0;
    assertErrors = 0;
    totalErrors = 0;
    cycleCount = 0;
    seedInit = $urandom(32'h5df7);

    // Hold reset and expect idle outputs on every cycle
    for (int c = 0; c < ResetCycles; c++) begin
      @(posedge clk);
      #1;
      if (c == ResetCycles - 1) rst = 1'b0;
      @(negedge clk);
      if (popValid !== 1'b0) begin
        $display("FAIL t=%0t popValid expected 0 got %b", $time, popValid);
        valueErrors++;
      end
      if (pushReady !== '0) begin
        $display("FAIL t=%0t pushReady expected 0000 got %b", $time, pushReady);
        valueErrors++;
      end
    end

    for (int r = 0; r < Rows; r++) begin
      runCycle(StimTable[r][4:1], StimTable[r][0]);
    end

    // Drain whatever is still held and end with one idle cycle
    while (srcValid != '0 || slotValid) begin
      runCycle('0, 1'b1);
    end
    runCycle('0, 1'b1);

    if (popValid !== 1'b0) begin
      $display("FAIL t=%0t popValid expected 0 got %b", $time, popValid);
      valueErrors++;
    end
    if (offFlow.size() != 0) begin
      $display("ERROR: %0d pushed words were never popped", offFlow.size());
      orderErrors++;
    end

    assertErrors = flowMuxFixedStable_i.flowMuxAsserts_i.failCount;
    totalErrors = valueErrors + orderErrors + assertErrors;

    $display("errors: %0d value, %0d order, %0d assertion, %0d total",
             valueErrors, orderErrors, assertErrors, totalErrors);
    if (totalErrors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule : flowMuxTb

`default_nettype wire
